// File: src.f
source/div_pkg.sv
source/div_ctrl_fsm.sv
source/div_iter_cnt.sv
source/div_core.sv
source/div_ovfl_cc.sv
source/div_unit.sv
testbench/tb_div_unit.sv

// File: testbench/div_testdata.txt
// op (0 udiv, 1 sdiv)  dividend  divisor  expected quotient  expected icc (n z v c)
// unsigned
0 0000000000000064 0000000A 0000000A 0
0 0000000000000005 00000007 00000000 4
0 00000000FFFFFFFF 00000001 FFFFFFFF 8
0 0000000100000000 00000002 80000000 8
0 0000000500000000 00000010 50000000 0
0 00000001FFFFFFFE 00000002 FFFFFFFF 8
0 123456789ABCDEF0 FFFFFFFF 12345678 0
0 0000000000001000 00000003 00000555 0
// unsigned overflow
0 0000000100000000 00000001 FFFFFFFF A
0 FFFFFFFFFFFFFFFF FFFFFFFF FFFFFFFF A
// signed, all sign combinations
1 0000000000000064 00000007 0000000E 0
1 FFFFFFFFFFFFFF9C 00000007 FFFFFFF2 8
1 0000000000000064 FFFFFFF9 FFFFFFF2 8
1 FFFFFFFFFFFFFF9C FFFFFFF9 0000000E 0
1 FFFFFFFFFFFFFFFD 00000005 00000000 4
1 0000000000000000 FFFFFFFF 00000000 4
1 FFFFFFFFFFFFFF9C 0000000A FFFFFFF6 8
1 FFFFFFFFC0000000 00000002 E0000000 8
1 000000007FFFFFFF 00000001 7FFFFFFF 0
1 FFFFFFFF80000000 00000001 80000000 8
// signed overflow
1 0000000080000000 00000001 7FFFFFFF 2
1 FFFFFFFF7FFFFFFF 00000001 80000000 A
1 8000000000000000 FFFFFFFF 7FFFFFFF 2
1 0000000100000000 FFFFFFFF 80000000 A

// File: testbench/tb_div_unit.sv
// div_unit testbench; run from the project root so testbench/div_testdata.txt is found
`timescale 1ns/1ps
`default_nettype none

module tb_div_unit;

   localparam int MAX_VEC = 64;

   // DUT ports
   logic              clk;
   logic              rst_n;
   logic              in_req;
   logic              in_ack;
   div_pkg::div_req_t in_data;
   logic              res_req;
   logic              res_ack;
   div_pkg::div_res_t res_data;

   // vectors from the data file
   logic [3:0]  op_v  [MAX_VEC];
   logic [63:0] dvd_v [MAX_VEC];
   logic [31:0] dsr_v [MAX_VEC];
   logic [31:0] quo_v [MAX_VEC];
   logic [3:0]  icc_v [MAX_VEC];
   integer      n_vec = 0;

   // file parsing scratch
   integer            fd;
   integer            rc;
   reg [8*256-1:0]    line;
   logic [3:0]        op_t;
   logic [63:0]       dvd_t;
   logic [31:0]       dsr_t;
   logic [31:0]       quo_t;
   logic [3:0]        icc_t;

   // bookkeeping
   integer value_errs = 0;
   integer proto_errs = 0;
   integer cyc = 0;
   integer timeout_limit = 100;
   integer accept_cyc = 0;
   integer seed = 46;
   integer delay;
   string  waiting_for = "reset";

   // values seen at the previous edge
   logic              rst_d1 = 1'b1;
   logic              rst_d2 = 1'b1;
   logic              in_req_d = 1'b0;
   logic              in_ack_d = 1'b0;
   logic              res_req_d = 1'b0;
   logic              res_ack_d = 1'b0;
   div_pkg::div_res_t res_data_d = '0;
   logic              op_busy = 1'b0;

   div_unit u_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_req   (in_req),
      .in_ack   (in_ack),
      .in_data  (in_data),
      .res_req  (res_req),
      .res_ack  (res_ack),
      .res_data (res_data)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #4 clk = ~clk;
      end
   end

   task automatic check_val(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
      if (actual !== expected) begin
         $display("ERR t=%0t %s actual=%h expected=%h", $time, name, actual, expected);
         value_errs = value_errs + 1;
      end
   endtask

   // put one vector on in_data and raise the request
   task automatic present_request(input int idx);
      in_data.op       = div_pkg::div_op_e'(op_v[idx][0]);
      in_data.dividend = dvd_v[idx];
      in_data.divisor  = dsr_v[idx];
      in_req           = 1'b1;
   endtask

   ////////////////////////////////////////
   // edge monitor and watchdog
   ////////////////////////////////////////

   // samples pre-edge values because inputs move 1 ns after the edge
   always @(posedge clk) begin
      cyc = cyc + 1;
      if (cyc >= timeout_limit) begin
         $display("timeout after %0d cycles, %s never came", cyc, waiting_for);
         $display("value errors: %0d  protocol errors: %0d", value_errs, proto_errs);
         $display("Test FAILED");
         $finish;
      end else begin
         // outputs cleared during reset and one edge past release
         if (!rst_d1 || !rst_d2) begin
            check_val("in_ack", in_ack, 1'b0);
            check_val("res_req", res_req, 1'b0);
         end
         if (rst_n && rst_d1) begin
            // E0 is the accepting edge
            if (in_req && !in_ack && !res_ack && !res_req) begin
               accept_cyc = cyc;
            end
            // res_req went up at the previous edge
            if (res_req && !res_req_d) begin
               check_val("res_req latency", cyc - 1 - accept_cyc, 65);
            end
            if (!in_ack && in_ack_d && in_req_d) begin
               $display("in_ack dropped at %0t while in_req was still high", $time);
               proto_errs = proto_errs + 1;
            end
            if (!res_ack && res_ack_d) begin
               op_busy = 1'b0;
            end
            if (in_ack && !in_ack_d) begin
               if (op_busy) begin
                  $display("second in_ack at %0t before res_ack returned low", $time);
                  proto_errs = proto_errs + 1;
               end
               op_busy = 1'b1;
            end
            // result held while the consumer stalls
            if (res_req_d && !res_ack_d) begin
               check_val("res_req", res_req, 1'b1);
               check_val("res_data", res_data, res_data_d);
            end
            if (res_req_d && res_ack_d) begin
               check_val("res_req", res_req, 1'b0);
            end
         end
         rst_d2     = rst_d1;
         rst_d1     = rst_n;
         in_req_d   = in_req;
         in_ack_d   = in_ack;
         res_req_d  = res_req;
         res_ack_d  = res_ack;
         res_data_d = res_data;
      end
   end

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////

   initial begin
      rst_n   = 1'b0;
      in_req  = 1'b0;
      res_ack = 1'b0;
      in_data = '0;

      // lines that do not parse as five hex fields are comments
      fd = $fopen("testbench/div_testdata.txt", "r");
      if (fd == 0) begin
         $display("could not open testbench/div_testdata.txt");
         $display("Test FAILED");
         $finish;
      end else begin
         while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 0) begin
               rc = $sscanf(line, "%h %h %h %h %h", op_t, dvd_t, dsr_t, quo_t, icc_t);
               if (rc == 5 && n_vec < MAX_VEC) begin
                  op_v[n_vec]  = op_t;
                  dvd_v[n_vec] = dvd_t;
                  dsr_v[n_vec] = dsr_t;
                  quo_v[n_vec] = quo_t;
                  icc_v[n_vec] = icc_t;
                  n_vec = n_vec + 1;
               end
            end
         end
         $fclose(fd);
         if (n_vec == 0) begin
            $display("no vectors found in testbench/div_testdata.txt");
            value_errs = value_errs + 1;
         end
         // 65 cycles of work plus handshakes and up to 7 stall cycles each
         timeout_limit = n_vec * 90 + 100;

         repeat (8) @(posedge clk);
         #1 rst_n = 1'b1;
         repeat (2) @(posedge clk);

         for (int i = 0; i < n_vec; i++) begin
            // an early request may already be up from the previous pass
            if (!in_req) begin
               @(posedge clk);
               #1;
               present_request(i);
            end
            waiting_for = "in_ack";
            @(posedge clk);
            #1;
            while (!in_ack) begin
               @(posedge clk);
               #1;
            end
            // in_req stays up a little past in_ack on some vectors
            repeat (i % 3) begin
               @(posedge clk);
               #1;
            end
            in_req      = 1'b0;
            waiting_for = "res_req";
            while (!res_req) begin
               @(posedge clk);
               #1;
            end
            check_val("res_data.quotient", res_data.quotient, quo_v[i]);
            check_val("res_data.icc", res_data.icc, icc_v[i]);

            // consumer back-pressure
            delay = $unsigned($random(seed)) % 8;
            repeat (delay) begin
               @(posedge clk);
               #1;
            end
            res_ack     = 1'b1;
            waiting_for = "res_req fall";
            while (res_req) begin
               @(posedge clk);
               #1;
            end
            // next request goes up while res_ack is still high and must wait
            if ((i % 2 == 1) && (i + 1 < n_vec)) begin
               present_request(i + 1);
               repeat (2) begin
                  @(posedge clk);
                  #1;
               end
            end
            res_ack = 1'b0;
         end
         repeat (3) @(posedge clk);

         $display("vectors: %0d  value errors: %0d  protocol errors: %0d",
                  n_vec, value_errs, proto_errs);
         if (value_errs == 0 && proto_errs == 0) begin
            $display("Test OK");
         end else begin
            $display("Test FAILED");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: source/div_unit.sv
// divider top: four-phase req/ack in and out, 65-cycle latency, zero divisor unspecified
`timescale 1ns/1ps
`default_nettype none

module div_unit (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              in_req,
   output logic              in_ack,
   input  div_pkg::div_req_t in_data,
   output logic              res_req,
   input  logic              res_ack,
   output div_pkg::div_res_t res_data
);

   // control to datapath
   logic              start;
   logic              iter_en;
   logic              check;
   logic              last_iter;

   // core to overflow block
   div_pkg::div_raw_t raw;

   ////////////////////////////////////////
   // control
   ////////////////////////////////////////

   div_ctrl_fsm u_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_req    (in_req),
      .res_ack   (res_ack),
      .last_iter (last_iter),
      .in_ack    (in_ack),
      .res_req   (res_req),
      .start     (start),
      .iter_en   (iter_en),
      .check     (check)
   );

   div_iter_cnt u_cnt (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start),
      .iter_en   (iter_en),
      .last_iter (last_iter)
   );

   ////////////////////////////////////////
   // datapath
   ////////////////////////////////////////

   div_core u_core (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start),
      .iter_en   (iter_en),
      .in_data   (in_data),
      .raw       (raw)
   );

   div_ovfl_cc u_ovfl (
      .clk       (clk),
      .rst_n     (rst_n),
      .check     (check),
      .raw       (raw),
      .res_data  (res_data)
   );

endmodule

`default_nettype wire

// File: source/div_ovfl_cc.sv
// 32-bit overflow saturation and icc; C is always 0, result held until the next check
`timescale 1ns/1ps
`default_nettype none

module div_ovfl_cc (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              check,
   input  div_pkg::div_raw_t raw,
   output div_pkg::div_res_t res_data
);

   logic [div_pkg::QUOT_W-1:0] mag_lo;
   logic                       upper_nz;
   logic                       ovfl_u;
   logic                       ovfl_pos;
   logic                       ovfl_neg;
   logic                       ovfl;
   logic [div_pkg::QUOT_W-1:0] sat_val;
   logic [div_pkg::QUOT_W-1:0] quo_fin;
   div_pkg::icc_t              icc_nxt;

   ////////////////////////////////////////
   // overflow detect
   ////////////////////////////////////////

   assign mag_lo   = raw.quo_mag[div_pkg::QUOT_W-1:0];
   assign upper_nz = |raw.quo_mag[div_pkg::DIVIDEND_W-1:div_pkg::QUOT_W];

   // unsigned: anything past 32 bits
   assign ovfl_u = upper_nz;

   // signed positive: above 0x7fffffff
   assign ovfl_pos = upper_nz | mag_lo[div_pkg::QUOT_W-1];

   // signed negative: above 0x80000000, so 0x80000000 itself still fits
   assign ovfl_neg = upper_nz |
                     (mag_lo[div_pkg::QUOT_W-1] & (|mag_lo[div_pkg::QUOT_W-2:0]));

   ////////////////////////////////////////
   // saturate or apply sign
   ////////////////////////////////////////

   always_comb begin
      if (raw.op == div_pkg::OP_UDIV) begin
         ovfl    = ovfl_u;
         sat_val = {div_pkg::QUOT_W{1'b1}};
      end else if (!raw.neg) begin
         ovfl    = ovfl_pos;
         sat_val = {1'b0, {(div_pkg::QUOT_W-1){1'b1}}};
      end else begin
         ovfl    = ovfl_neg;
         sat_val = {1'b1, {(div_pkg::QUOT_W-1){1'b0}}};
      end

      // neg is never set for udiv
      if (ovfl) begin
         quo_fin = sat_val;
      end else if (raw.neg) begin
         quo_fin = -mag_lo;
      end else begin
         quo_fin = mag_lo;
      end
   end

   // icc taken from the final, saturated quotient
   assign icc_nxt.n = quo_fin[div_pkg::QUOT_W-1];
   assign icc_nxt.z = (quo_fin == '0);
   assign icc_nxt.v = ovfl;
   assign icc_nxt.c = 1'b0;

   ////////////////////////////////////////
   // result register
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         res_data <= '0;
      end else if (check) begin
         res_data.quotient <= quo_fin;
         res_data.icc      <= icc_nxt;
      end
   end

endmodule

`default_nettype wire

// File: source/div_core.sv
// restoring shift-subtract core on magnitudes; signs fixed later, divisor of zero not handled
`timescale 1ns/1ps
`default_nettype none

module div_core (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              start,
   input  logic              iter_en,
   input  div_pkg::div_req_t in_data,
   output div_pkg::div_raw_t raw
);

   // operand sign and magnitude at capture
   logic                            is_sdiv;
   logic                            dvd_neg;
   logic                            dsr_neg;
   logic [div_pkg::DIVIDEND_W-1:0]  dvd_mag;
   logic [div_pkg::DIVISOR_W-1:0]   dsr_mag;

   // iteration state
   logic [div_pkg::DIVIDEND_W-1:0]  dq_q;
   logic [div_pkg::DIVISOR_W-1:0]   dsr_q;
   logic [div_pkg::DIVISOR_W-1:0]   rem_q;

   // one step
   logic [div_pkg::DIVISOR_W:0]     rem_shift;
   logic [div_pkg::DIVISOR_W+1:0]   rem_diff;
   logic                            q_bit;

   // op and result sign kept for the overflow block
   div_pkg::div_op_e                op_q;
   logic                            neg_q;

   ////////////////////////////////////////
   // magnitude conversion
   ////////////////////////////////////////

   assign is_sdiv = (in_data.op == div_pkg::OP_SDIV);

   // sign bits only count for signed divide
   assign dvd_neg = is_sdiv & in_data.dividend[div_pkg::DIVIDEND_W-1];
   assign dsr_neg = is_sdiv & in_data.divisor[div_pkg::DIVISOR_W-1];

   // most negative value maps onto itself, which is also its magnitude
   assign dvd_mag = dvd_neg ? -in_data.dividend : in_data.dividend;
   assign dsr_mag = dsr_neg ? -in_data.divisor : in_data.divisor;

   ////////////////////////////////////////
   // shift-subtract step
   ////////////////////////////////////////

   // next dividend bit comes off the top of dq_q
   assign rem_shift = {rem_q, dq_q[div_pkg::DIVIDEND_W-1]};

   // extra top bit acts as the borrow out
   assign rem_diff = {1'b0, rem_shift} - {2'b00, dsr_q};

   // subtract only if the remainder stays non-negative
   assign q_bit = ~rem_diff[div_pkg::DIVISOR_W+1];

   // dq_q starts as the dividend and fills with quotient bits from the bottom
   // after 64 steps the dividend is gone and only the quotient is left
   // the remainder is always below the divisor so 32 bits hold it between steps
   always_ff @(posedge clk) begin
      if (start) begin
         dq_q  <= dvd_mag;
         dsr_q <= dsr_mag;
         rem_q <= '0;
      end else if (iter_en) begin
         dq_q <= {dq_q[div_pkg::DIVIDEND_W-2:0], q_bit};
         if (q_bit) begin
            rem_q <= rem_diff[div_pkg::DIVISOR_W-1:0];
         end else begin
            rem_q <= rem_shift[div_pkg::DIVISOR_W-1:0];
         end
      end
   end

   ////////////////////////////////////////
   // op and sign flags
   ////////////////////////////////////////

   // truncation toward zero: quotient sign is the xor of operand signs
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         op_q  <= div_pkg::OP_UDIV;
         neg_q <= 1'b0;
      end else if (start) begin
         op_q  <= in_data.op;
         neg_q <= dvd_neg ^ dsr_neg;
      end
   end

   // valid in check, one cycle after the last step
   assign raw.op      = op_q;
   assign raw.neg     = neg_q;
   assign raw.quo_mag = dq_q;

endmodule

`default_nettype wire

// File: source/div_iter_cnt.sv
// 6-bit step counter; cleared by start, wraps to 0 on the 64th step
`timescale 1ns/1ps
`default_nettype none

module div_iter_cnt (
   input  logic clk,
   input  logic rst_n,
   input  logic start,
   input  logic iter_en,
   output logic last_iter
);

   logic [div_pkg::CNT_W-1:0] cnt;

   // start wins over a step, though the FSM never asserts both
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (start) begin
         cnt <= '0;
      end else if (iter_en) begin
         cnt <= cnt + 1'b1;
      end
   end

   // terminal count
   // high during the final step, before the wrap
   assign last_iter = (cnt == div_pkg::ITER_LAST);

endmodule

`default_nettype wire

// File: source/div_ctrl_fsm.sv
// divide sequencer: one op in flight, res_req high 65 cycles after the accepting edge
`timescale 1ns/1ps
`default_nettype none

module div_ctrl_fsm (
   input  logic clk,
   input  logic rst_n,
   input  logic in_req,
   input  logic res_ack,
   input  logic last_iter,
   output logic in_ack,
   output logic res_req,
   output logic start,
   output logic iter_en,
   output logic check
);

   div_pkg::div_state_e state;
   div_pkg::div_state_e state_nxt;

   ////////////////////////////////////////
   // state decode
   ////////////////////////////////////////

   // accept only when both handshakes are back at rest
   assign start = (state == div_pkg::ST_IDLE) & in_req & ~in_ack & ~res_ack;

   // one shift-subtract step per cycle in run
   assign iter_en = (state == div_pkg::ST_RUN);

   // overflow check and cc capture
   assign check = (state == div_pkg::ST_CHECK);

   ////////////////////////////////////////
   // next state
   ////////////////////////////////////////

   always_comb begin
      state_nxt = state;
      case (state)
         div_pkg::ST_IDLE: begin
            if (start) begin
               state_nxt = div_pkg::ST_RUN;
            end
         end
         div_pkg::ST_RUN: begin
            // last_iter is up during the 64th step
            if (last_iter) begin
               state_nxt = div_pkg::ST_CHECK;
            end
         end
         div_pkg::ST_CHECK: begin
            state_nxt = div_pkg::ST_DONE;
         end
         div_pkg::ST_DONE: begin
            // hold result until the consumer takes it
            if (res_ack) begin
               state_nxt = div_pkg::ST_IDLE;
            end
         end
         default: begin
            state_nxt = div_pkg::ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= div_pkg::ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   ////////////////////////////////////////
   // handshake registers
   ////////////////////////////////////////

   // in_ack: set on accept, dropped once in_req is seen low
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_ack <= 1'b0;
      end else if (start) begin
         in_ack <= 1'b1;
      end else if (!in_req) begin
         in_ack <= 1'b0;
      end
   end

   // res_req follows the done state exactly
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         res_req <= 1'b0;
      end else if (state == div_pkg::ST_CHECK) begin
         res_req <= 1'b1;
      end else if ((state == div_pkg::ST_DONE) && res_ack) begin
         res_req <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: source/div_pkg.sv
// shared widths, enums and structs for the 64/32 divider; zero divisor gives an unspecified result
`default_nettype none

package div_pkg;

   ////////////////////////////////////////
   // widths and counter limit
   ////////////////////////////////////////

   // dividend, divisor and architected quotient widths
   localparam int DIVIDEND_W = 64;
   localparam int DIVISOR_W  = 32;
   localparam int QUOT_W     = 32;

   // one iteration per dividend bit, counter wraps after the last
   localparam int CNT_W = 6;
   localparam logic [CNT_W-1:0] ITER_LAST = 6'd63;

   ////////////////////////////////////////
   // enums
   ////////////////////////////////////////

   // SPARC UDIV / SDIV
   typedef enum logic {
      OP_UDIV = 1'b0,
      OP_SDIV = 1'b1
   } div_op_e;

   // sequencing states, overflow check folded into one state
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_RUN   = 2'd1,
      ST_CHECK = 2'd2,
      ST_DONE  = 2'd3
   } div_state_e;

   ////////////////////////////////////////
   // structs
   ////////////////////////////////////////

   // request payload, 97 bits
   typedef struct packed {
      div_op_e                 op;
      logic [DIVIDEND_W-1:0]   dividend;
      logic [DIVISOR_W-1:0]    divisor;
   } div_req_t;

   // integer condition codes, same bit order as the SPARC icc field
   typedef struct packed {
      logic n;
      logic z;
      logic v;
      logic c;
   } icc_t;

   // result payload, 36 bits
   typedef struct packed {
      logic [QUOT_W-1:0] quotient;
      icc_t              icc;
   } div_res_t;

   // core to overflow block, quotient still an unsigned magnitude
   typedef struct packed {
      div_op_e               op;
      logic                  neg;
      logic [DIVIDEND_W-1:0] quo_mag;
   } div_raw_t;

endpackage

`default_nettype wire
